// ==== rtl/bp_pkg.sv ====
package bp_pkg;

    // prediction mode, value 2'b11 is not defined
    typedef enum logic [1:0] {
        mode_static  = 2'b00,
        mode_global  = 2'b01,
        mode_bimodal = 2'b10
    } bp_mode_e;

    // mode after reset
    localparam bp_mode_e mode_reset = mode_static;

    // host register map
    typedef enum logic [3:0] {
        reg_mode        = 4'h0,
        reg_control     = 4'h1,
        reg_branches    = 4'h2,
        reg_mispredicts = 4'h3
    } bp_reg_addr_e;

    // live configuration, config block to predictor
    typedef struct packed {
        bp_mode_e mode;
        logic     freeze;
    } bp_cfg_t;

    // one decoded branch waiting for resolution
    typedef struct packed {
        logic [31:0] pc;
        logic        backward;
        logic        predicted;
    } bp_entry_t;

    typedef struct packed {
        logic [15:0] branches;
        logic [15:0] mispredicts;
    } bp_stats_t;

    // weakly not taken
    localparam logic [1:0] counter_init = 2'b01;

    // 2-bit saturating step, up on taken, down on not taken
    function automatic logic [1:0] counter_next(input logic [1:0] cnt, input logic taken);
        logic [1:0] nxt;
        if (taken) begin
            nxt = (cnt == 2'b11) ? 2'b11 : cnt + 2'd1;
        end else begin
            nxt = (cnt == 2'b00) ? 2'b00 : cnt - 2'd1;
        end
        return nxt;
    endfunction

endpackage

// ==== rtl/bp_config_regs.sv ====
`timescale 1ns/1ps

module bp_config_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cfg_write,
    input  bp_pkg::bp_reg_addr_e cfg_addr,
    input  logic [31:0]          cfg_wdata,
    input  bp_pkg::bp_stats_t    stats,
    output bp_pkg::bp_cfg_t      cfg,
    output logic                 stats_clear,
    output logic [31:0]          cfg_rdata
);

    bp_pkg::bp_cfg_t cfg_q;

    // mode and freeze registers
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_q.mode   <= bp_pkg::mode_reset;
            cfg_q.freeze <= 1'b0;
        end else if (cfg_write) begin
            case (cfg_addr)
                bp_pkg::reg_mode: begin
                    // no mode for 2'b11 so the old value stays
                    if (cfg_wdata[1:0] != 2'b11) begin
                        cfg_q.mode <= bp_pkg::bp_mode_e'(cfg_wdata[1:0]);
                    end
                end
                bp_pkg::reg_control: cfg_q.freeze <= cfg_wdata[0];
                default: cfg_q <= cfg_q;
            endcase
        end
    end

    assign cfg = cfg_q;

    // clear pulse lasts as long as the write strobe
    // stats react on the next edge
    assign stats_clear = cfg_write && (cfg_addr == bp_pkg::reg_control) && cfg_wdata[1];

    // readback mux
    // control register reads as zero
    always_comb begin
        case (cfg_addr)
            bp_pkg::reg_mode:        cfg_rdata = {30'd0, cfg_q.mode};
            bp_pkg::reg_branches:    cfg_rdata = {16'd0, stats.branches};
            bp_pkg::reg_mispredicts: cfg_rdata = {16'd0, stats.mispredicts};
            default:                 cfg_rdata = 32'd0;
        endcase
    end

    // host writes never leave the predictor in an undefined mode
    mode_defined_a: assert property (@(posedge clk) disable iff (reset)
        cfg_q.mode inside {bp_pkg::mode_static, bp_pkg::mode_global, bp_pkg::mode_bimodal});

endmodule

// ==== rtl/pattern_table.sv ====
`timescale 1ns/1ps

module pattern_table #(
    parameter int TABLE_BITS = 5
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [TABLE_BITS-1:0] rd_index,
    output logic [1:0]            rd_counter,
    input  logic                  upd,
    input  logic [TABLE_BITS-1:0] upd_index,
    input  logic                  upd_taken
);

    localparam int TABLE_SIZE = 1 << TABLE_BITS;

    // one 2-bit counter per entry
    // 00/01 lean not taken, 10/11 lean taken
    logic [1:0] counters [TABLE_SIZE];

    // next value of the entry being updated
    logic [1:0] upd_next;

    assign upd_next = bp_pkg::counter_next(counters[upd_index], upd_taken);

    // whole table back to weakly not taken in a single cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < TABLE_SIZE; i++) begin
                counters[i] <= bp_pkg::counter_init;
            end
        end else if (upd) begin
            counters[upd_index] <= upd_next;
        end
    end

    // combinational lookup
    // same-cycle update is not forwarded, a decode sees the old counter
    assign rd_counter = counters[rd_index];

    // update index comes from a queued pc
    // must be a known entry inside the table
    upd_in_range_a: assert property (@(posedge clk) disable iff (reset)
        upd |-> (!$isunknown(upd_index) && (int'(upd_index) < TABLE_SIZE)));

endmodule

// ==== rtl/branch_queue.sv ====
`timescale 1ns/1ps

module branch_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              push,
    input  bp_pkg::bp_entry_t push_entry,
    input  logic              pop,
    output bp_pkg::bp_entry_t head,
    output logic              full
);

    localparam int PTR_BITS   = $clog2(QUEUE_DEPTH);
    localparam int COUNT_BITS = $clog2(QUEUE_DEPTH + 1);

    // branch storage, oldest entry at rd_ptr
    bp_pkg::bp_entry_t entries [QUEUE_DEPTH];

    logic [PTR_BITS-1:0]   wr_ptr;
    logic [PTR_BITS-1:0]   rd_ptr;
    logic [COUNT_BITS-1:0] count;
    logic                  empty;

    assign full  = (count == COUNT_BITS'(QUEUE_DEPTH));
    assign empty = (count == '0);

    // data slots, no reset needed
    // when full, push and pop share the slot the pop frees
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_entry;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // occupancy
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // resolving branch is always the oldest one
    assign head = entries[rd_ptr];

    // pipeline back-pressure rules
    no_overflow_a: assert property (@(posedge clk) disable iff (reset)
        (push && full) |-> pop);

    no_underflow_a: assert property (@(posedge clk) disable iff (reset)
        pop |-> !empty);

endmodule

// ==== rtl/branch_predictor.sv ====
`timescale 1ns/1ps

module branch_predictor #(
    parameter int TABLE_BITS = 5
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  decode,
    input  logic [31:0]           pc,
    input  logic [31:0]           offset,
    input  logic                  resolve,
    input  logic                  taken,
    input  bp_pkg::bp_cfg_t       cfg,
    output logic [31:0]           branch_addr,
    output logic                  prediction,
    output logic [TABLE_BITS-1:0] rd_index,
    input  logic [1:0]            rd_counter,
    output logic                  upd,
    output logic [TABLE_BITS-1:0] upd_index,
    output logic                  upd_taken,
    output logic                  push,
    output bp_pkg::bp_entry_t     push_entry,
    output logic                  pop,
    input  bp_pkg::bp_entry_t     head,
    output logic                  mispredict
);

    logic       backward;
    logic       direction;
    logic [1:0] global_counter;
    logic       counter_update;

    // target is pc relative
    assign branch_addr = pc + offset;

    // negative offset means a loop back edge
    assign backward = offset[31];

    // word aligned pc bits pick the table entry
    assign rd_index = pc[TABLE_BITS+1:2];

    // backward branches always taken
    // forward branches follow the mode
    always_comb begin
        case (cfg.mode)
            bp_pkg::mode_global:  direction = backward | global_counter[1];
            bp_pkg::mode_bimodal: direction = backward | rd_counter[1];
            default:              direction = backward;
        endcase
    end

    assign prediction = decode & direction;

    // every decoded branch enters the queue with its guess
    assign push                 = decode;
    assign push_entry.pc        = pc;
    assign push_entry.backward  = backward;
    assign push_entry.predicted = prediction;

    // memory stage resolves the oldest branch
    assign pop = resolve;

    // only forward branches train, and not while frozen
    assign counter_update = resolve && !head.backward && !cfg.freeze;

    // single shared counter for global mode
    always_ff @(posedge clk) begin
        if (reset) begin
            global_counter <= bp_pkg::counter_init;
        end else if (counter_update && (cfg.mode == bp_pkg::mode_global)) begin
            global_counter <= bp_pkg::counter_next(global_counter, taken);
        end
    end

    // bimodal training goes to the table
    // index from the queued pc, not the decode pc
    assign upd       = counter_update && (cfg.mode == bp_pkg::mode_bimodal);
    assign upd_index = head.pc[TABLE_BITS+1:2];
    assign upd_taken = taken;

    // guess made at decode vs outcome now
    assign mispredict = resolve && (head.predicted != taken);

endmodule

// ==== rtl/predict_stats.sv ====
`timescale 1ns/1ps

module predict_stats (
    input  logic              clk,
    input  logic              reset,
    input  logic              resolve,
    input  logic              mispredict,
    input  logic              clear,
    output bp_pkg::bp_stats_t stats
);

    logic [15:0] branches_q;
    logic [15:0] mispredicts_q;

    // resolved branch count, sticks at all ones
    always_ff @(posedge clk) begin
        if (reset) begin
            branches_q <= '0;
        end else if (clear) begin
            // clear beats a count in the same cycle
            branches_q <= '0;
        end else if (resolve && (branches_q != '1)) begin
            branches_q <= branches_q + 16'd1;
        end
    end

    // misprediction count, same saturation
    always_ff @(posedge clk) begin
        if (reset) begin
            mispredicts_q <= '0;
        end else if (clear) begin
            mispredicts_q <= '0;
        end else if (resolve && mispredict && (mispredicts_q != '1)) begin
            mispredicts_q <= mispredicts_q + 16'd1;
        end
    end

    assign stats.branches    = branches_q;
    assign stats.mispredicts = mispredicts_q;

    // every miss is also a resolution
    // so misses never outnumber branches
    miss_bound_a: assert property (@(posedge clk) disable iff (reset)
        mispredicts_q <= branches_q);

endmodule

// ==== rtl/branch_unit_top.sv ====
`timescale 1ns/1ps

module branch_unit_top #(
    parameter int TABLE_BITS  = 5,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 decode,
    input  logic [31:0]          pc,
    input  logic [31:0]          offset,
    input  logic                 resolve,
    input  logic                 taken,
    input  logic                 cfg_write,
    input  bp_pkg::bp_reg_addr_e cfg_addr,
    input  logic [31:0]          cfg_wdata,
    output logic [31:0]          branch_addr,
    output logic                 prediction,
    output logic                 queue_full,
    output logic [31:0]          cfg_rdata
);

    bp_pkg::bp_cfg_t       cfg;
    bp_pkg::bp_stats_t     stats;
    logic                  stats_clear;
    logic [TABLE_BITS-1:0] rd_index;
    logic [1:0]            rd_counter;
    logic                  upd;
    logic [TABLE_BITS-1:0] upd_index;
    logic                  upd_taken;
    logic                  push;
    bp_pkg::bp_entry_t     push_entry;
    logic                  pop;
    bp_pkg::bp_entry_t     head;
    logic                  mispredict;

    // host register block
    bp_config_regs u_config_regs (
        .clk(clk), .reset(reset),
        .cfg_write(cfg_write), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
        .stats(stats), .cfg(cfg), .stats_clear(stats_clear), .cfg_rdata(cfg_rdata)
    );

    // target, direction and training
    branch_predictor #(.TABLE_BITS(TABLE_BITS)) u_predictor (
        .clk(clk), .reset(reset),
        .decode(decode), .pc(pc), .offset(offset),
        .resolve(resolve), .taken(taken), .cfg(cfg),
        .branch_addr(branch_addr), .prediction(prediction),
        .rd_index(rd_index), .rd_counter(rd_counter),
        .upd(upd), .upd_index(upd_index), .upd_taken(upd_taken),
        .push(push), .push_entry(push_entry), .pop(pop), .head(head),
        .mispredict(mispredict)
    );

    // bimodal counters
    pattern_table #(.TABLE_BITS(TABLE_BITS)) u_table (
        .clk(clk), .reset(reset),
        .rd_index(rd_index), .rd_counter(rd_counter),
        .upd(upd), .upd_index(upd_index), .upd_taken(upd_taken)
    );

    // decode to memory stage tracking
    branch_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
        .clk(clk), .reset(reset),
        .push(push), .push_entry(push_entry),
        .pop(pop), .head(head), .full(queue_full)
    );

    predict_stats u_stats (
        .clk(clk), .reset(reset),
        .resolve(resolve), .mispredict(mispredict),
        .clear(stats_clear), .stats(stats)
    );

endmodule

// ==== bench/tb_branch_unit.sv ====
`timescale 1ns/1ps

module tb_branch_unit;

    localparam int TABLE_BITS  = 5;
    localparam int QUEUE_DEPTH = 4;

    logic                 clk;
    logic                 reset;
    logic                 decode;
    logic [31:0]          pc;
    logic [31:0]          offset;
    logic                 resolve;
    logic                 taken;
    logic                 cfg_write;
    bp_pkg::bp_reg_addr_e cfg_addr;
    logic [31:0]          cfg_wdata;
    logic [31:0]          branch_addr;
    logic                 prediction;
    logic                 queue_full;
    logic [31:0]          cfg_rdata;

    // reference model state
    bp_pkg::bp_mode_e  model_mode;
    logic              model_freeze;
    logic [1:0]        model_gc;
    logic [1:0]        model_table [1 << TABLE_BITS];
    bp_pkg::bp_entry_t model_q [$];
    int                model_count;
    logic [15:0]       model_branches;
    logic [15:0]       model_mispredicts;
    logic              exp_pred;
    logic [31:0]       exp_rdata;
    logic              exp_dir;

    string test_name;
    int    errors;
    int    errors_at_start;
    int    tests_run;
    int    tests_failed;

    branch_unit_top #(.TABLE_BITS(TABLE_BITS), .QUEUE_DEPTH(QUEUE_DEPTH)) DUT (
        .clk(clk), .reset(reset),
        .decode(decode), .pc(pc), .offset(offset),
        .resolve(resolve), .taken(taken),
        .cfg_write(cfg_write), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
        .branch_addr(branch_addr), .prediction(prediction),
        .queue_full(queue_full), .cfg_rdata(cfg_rdata)
    );

    always #2 clk = ~clk;

    // 2-bit saturating counter rule
    function automatic logic [1:0] saturate_step(input logic [1:0] c, input logic up);
        logic [1:0] r;
        r = c;
        if (up && c != 2'b11) begin
            r = c + 2'd1;
        end else if (!up && c != 2'b00) begin
            r = c - 2'd1;
        end
        return r;
    endfunction

    // expected direction for the branch on the decode inputs
    always_comb begin
        case (model_mode)
            bp_pkg::mode_global:  exp_dir = offset[31] | model_gc[1];
            bp_pkg::mode_bimodal: exp_dir = offset[31] | model_table[pc[TABLE_BITS+1:2]][1];
            default:              exp_dir = offset[31];
        endcase
        exp_pred = decode & exp_dir;
    end

    // expected readback
    // control register is write only
    always_comb begin
        case (cfg_addr)
            bp_pkg::reg_mode:        exp_rdata = {30'd0, model_mode};
            bp_pkg::reg_branches:    exp_rdata = {16'd0, model_branches};
            bp_pkg::reg_mispredicts: exp_rdata = {16'd0, model_mispredicts};
            default:                 exp_rdata = 32'd0;
        endcase
    end

    // model advances on the same edge as the DUT
    always @(posedge clk) begin : model_update
        logic              pred_now;
        logic              clear_now;
        bp_pkg::bp_entry_t e;
        logic [TABLE_BITS-1:0] idx;
        if (reset) begin
            model_mode   = bp_pkg::mode_static;
            model_freeze = 1'b0;
            model_gc     = 2'b01;
            for (int i = 0; i < (1 << TABLE_BITS); i++) begin
                model_table[i] = 2'b01;
            end
            model_q.delete();
            model_count       = 0;
            model_branches    = '0;
            model_mispredicts = '0;
        end else begin
            // decode sees counters from before this edge
            pred_now  = exp_pred;
            clear_now = cfg_write && (cfg_addr == bp_pkg::reg_control) && cfg_wdata[1];
            if (clear_now) begin
                model_branches    = '0;
                model_mispredicts = '0;
            end
            if (resolve && model_q.size() > 0) begin
                e = model_q.pop_front();
                // only forward branches train
                if (!e.backward && !model_freeze) begin
                    if (model_mode == bp_pkg::mode_global) begin
                        model_gc = saturate_step(model_gc, taken);
                    end else if (model_mode == bp_pkg::mode_bimodal) begin
                        idx = e.pc[TABLE_BITS+1:2];
                        model_table[idx] = saturate_step(model_table[idx], taken);
                    end
                end
                if (!clear_now && model_branches != 16'hffff) begin
                    model_branches = model_branches + 16'd1;
                end
                if (!clear_now && e.predicted != taken && model_mispredicts != 16'hffff) begin
                    model_mispredicts = model_mispredicts + 16'd1;
                end
            end
            if (decode) begin
                e.pc        = pc;
                e.backward  = offset[31];
                e.predicted = pred_now;
                model_q.push_back(e);
            end
            model_count = model_q.size();
            // config write lands after this edge's training
            if (cfg_write && cfg_addr == bp_pkg::reg_mode && cfg_wdata[1:0] != 2'b11) begin
                model_mode = bp_pkg::bp_mode_e'(cfg_wdata[1:0]);
            end
            if (cfg_write && cfg_addr == bp_pkg::reg_control) begin
                model_freeze = cfg_wdata[0];
            end
        end
    end

    task automatic value_error(input string check, input logic [31:0] expected,
                               input logic [31:0] actual);
        errors++;
        $display("Fail %s (%s): expected %h actual %h", test_name, check, expected, actual);
    endtask

    task automatic timeout_error(input string what);
        errors++;
        $display("Timeout in %s: %s", test_name, what);
    endtask

    // output checks against the model
    target_a: assert property (@(posedge clk) disable iff (reset)
        branch_addr == pc + offset)
        else value_error("target", $sampled(pc + offset), $sampled(branch_addr));

    gating_a: assert property (@(posedge clk) disable iff (reset)
        !decode |-> !prediction)
        else value_error("gating", 32'd0, $sampled(prediction));

    direction_a: assert property (@(posedge clk) disable iff (reset)
        decode |-> (prediction == exp_pred))
        else value_error("direction", $sampled(exp_pred), $sampled(prediction));

    static_a: assert property (@(posedge clk) disable iff (reset)
        (decode && model_mode == bp_pkg::mode_static) |-> (prediction == offset[31]))
        else value_error("static direction", $sampled(offset[31]), $sampled(prediction));

    full_a: assert property (@(posedge clk) disable iff (reset)
        queue_full == (model_count == QUEUE_DEPTH))
        else value_error("queue_full", $sampled(model_count == QUEUE_DEPTH), $sampled(queue_full));

    readback_a: assert property (@(posedge clk) disable iff (reset)
        (cfg_addr != bp_pkg::reg_control) |-> (cfg_rdata == exp_rdata))
        else value_error("readback", $sampled(exp_rdata), $sampled(cfg_rdata));

    // one clock of pipeline inputs
    // driven just after the edge
    task automatic drive_cycle(input logic dec, input logic [31:0] p, input logic [31:0] off,
                               input logic res, input logic tk);
        decode  = dec;
        pc      = p;
        offset  = off;
        resolve = res;
        taken   = tk;
        @(posedge clk);
        #1;
        decode  = 1'b0;
        resolve = 1'b0;
        taken   = 1'b0;
    endtask

    task automatic write_reg(input bp_pkg::bp_reg_addr_e addr, input logic [31:0] data);
        cfg_write = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge clk);
        #1;
        cfg_write = 1'b0;
        cfg_addr  = bp_pkg::reg_mode;
    endtask

    // readback itself is checked by readback_a
    task automatic read_reg(input bp_pkg::bp_reg_addr_e addr);
        cfg_addr = addr;
        @(posedge clk);
        #1;
        cfg_addr = bp_pkg::reg_mode;
    endtask

    // decode then resolve so the queue stays shallow
    task automatic run_branch(input logic [31:0] p, input logic [31:0] off, input logic tk);
        drive_cycle(1'b1, p, off, 1'b0, 1'b0);
        drive_cycle(1'b0, p, off, 1'b1, tk);
    endtask

    task automatic drain_queue();
        int guard;
        guard = 0;
        while (model_count > 0 && guard < QUEUE_DEPTH + 4) begin
            drive_cycle(1'b0, pc, offset, 1'b1, 1'($urandom % 2));
            guard++;
        end
        if (model_count > 0) begin
            timeout_error("queue did not drain");
        end
    endtask

    // random decode/resolve mix that obeys back-pressure
    task automatic random_traffic(input int n, input logic [31:0] pc_mask);
        logic dec;
        logic res;
        for (int i = 0; i < n; i++) begin
            dec = 1'($urandom % 2);
            res = (model_count > 0) && 1'($urandom % 2);
            if (dec && model_count == QUEUE_DEPTH && !res) begin
                dec = 1'b0;
            end
            drive_cycle(dec, $urandom & pc_mask, $urandom, res, 1'($urandom % 2));
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors > errors_at_start) begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - errors_at_start);
        end else begin
            $display("test %s: ok", test_name);
        end
    endtask

    initial begin
        int n;
        clk       = 1'b0;
        reset     = 1'b1;
        decode    = 1'b0;
        pc        = '0;
        offset    = '0;
        resolve   = 1'b0;
        taken     = 1'b0;
        cfg_write = 1'b0;
        cfg_addr  = bp_pkg::reg_mode;
        cfg_wdata = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "reset";
        void'($urandom(65));
        apply_reset();

        start_test("target_gating");
        random_traffic(60, 32'hffff_ffff);
        drain_queue();
        end_test();

        // loop-heavy history must not bend static predictions
        start_test("static_mode");
        write_reg(bp_pkg::reg_mode, 32'd0);
        read_reg(bp_pkg::reg_mode);
        repeat (4) run_branch(32'h0000_0200, 32'h10, 1'b1);
        repeat (2) run_branch(32'h0000_0200, -32'sd16, 1'b0);
        random_traffic(20, 32'h0000_0ffc);
        drain_queue();
        end_test();

        start_test("bimodal_mode");
        write_reg(bp_pkg::reg_mode, 32'd2);
        repeat (2) run_branch(32'h0000_0100, 32'h20, 1'b1);
        run_branch(32'h0000_0100, 32'h20, 1'b1);
        // alias one table span up and neighbour one word up
        run_branch(32'h0000_0100 + (32'd1 << (TABLE_BITS + 2)), 32'h20, 1'b1);
        run_branch(32'h0000_0104, 32'h20, 1'b0);
        repeat (3) run_branch(32'h0000_0100, 32'h20, 1'b0);
        run_branch(32'h0000_0100, 32'h20, 1'b0);
        // backward outcomes leave the entry alone
        repeat (3) run_branch(32'h0000_0100, -32'sd8, 1'b1);
        run_branch(32'h0000_0100, 32'h20, 1'b0);
        end_test();

        start_test("global_freeze");
        write_reg(bp_pkg::reg_mode, 32'd1);
        repeat (4) run_branch($urandom & 32'h0000_fffc, 32'h40, 1'b1);
        repeat (4) run_branch($urandom & 32'h0000_fffc, 32'h40, 1'b0);
        write_reg(bp_pkg::reg_control, 32'd1);
        repeat (3) run_branch($urandom & 32'h0000_fffc, 32'h40, 1'b1);
        write_reg(bp_pkg::reg_control, 32'd0);
        repeat (2) run_branch($urandom & 32'h0000_fffc, 32'h40, 1'b1);
        end_test();

        start_test("statistics");
        write_reg(bp_pkg::reg_control, 32'd2);
        write_reg(bp_pkg::reg_mode, 32'd2);
        random_traffic(80, 32'h0000_00fc);
        drain_queue();
        read_reg(bp_pkg::reg_branches);
        read_reg(bp_pkg::reg_mispredicts);
        write_reg(bp_pkg::reg_control, 32'd2);
        read_reg(bp_pkg::reg_branches);
        read_reg(bp_pkg::reg_mispredicts);
        // undefined mode value is dropped
        write_reg(bp_pkg::reg_mode, 32'd3);
        read_reg(bp_pkg::reg_mode);
        end_test();

        start_test("back_pressure");
        n = 0;
        while (!queue_full && n < QUEUE_DEPTH + 2) begin
            drive_cycle(1'b1, 32'h0000_0400 + 4 * n, 32'h10, 1'b0, 1'b0);
            n++;
        end
        if (!queue_full) begin
            timeout_error("queue_full never rose");
        end
        // push and pop together while full
        drive_cycle(1'b1, 32'h0000_0500, 32'h10, 1'b1, 1'b0);
        drive_cycle(1'b0, 32'h0000_0500, 32'h10, 1'b1, 1'b1);
        drain_queue();
        repeat (QUEUE_DEPTH) drive_cycle(1'b1, 32'h0000_0600, 32'h10, 1'b0, 1'b0);
        apply_reset();
        drive_cycle(1'b0, 32'h0000_0600, 32'h10, 1'b0, 1'b0);
        end_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
rtl/bp_pkg.sv
rtl/bp_config_regs.sv
rtl/pattern_table.sv
rtl/branch_queue.sv
rtl/branch_predictor.sv
rtl/predict_stats.sv
rtl/branch_unit_top.sv
bench/tb_branch_unit.sv
